/* trig_pkg.sv */
package trig_pkg;

  // sizes shared by the register map and the sequencer
  localparam int num_triggers  = 4;
  localparam int counter_width = 16;
  localparam int slot_width    = 2;
  localparam int wb_data_width = 32;
  localparam int wb_addr_width = 3;

  // control register fields
  localparam int ctrl_arm_bit    = 0;
  localparam int ctrl_bypass_bit = 1;
  localparam int ctrl_slot_lsb   = 4; // lsb of the last slot field

  // status register fields
  localparam int stat_armed_bit = 0;
  localparam int stat_fired_bit = 1;
  localparam int stat_early_bit = 2;
  localparam int stat_late_bit  = 3;

  // word addresses on the wishbone port
  typedef enum logic [wb_addr_width-1:0] {
    reg_ctrl      = 3'd0,
    reg_status    = 3'd1, // read only
    reg_min_wait0 = 3'd2,
    reg_min_wait1 = 3'd3,
    reg_min_wait2 = 3'd4,
    reg_max_wait0 = 3'd5,
    reg_max_wait1 = 3'd6,
    reg_max_wait2 = 3'd7
  } reg_addr_e;

  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_wait_first = 2'd1, // armed and waiting for slot 0
    st_wait_next  = 2'd2  // gap counter running
  } seq_state_e;

endpackage

/* seq_cfg_if.sv */
`timescale 1ns/1ps

interface seq_cfg_if;
  import trig_pkg::*;

  // configuration from the register file to the sequencer
  logic                     arm;
  logic                     bypass;
  logic [slot_width-1:0]    last_slot;
  logic [counter_width-1:0] min_wait [num_triggers-1];
  logic [counter_width-1:0] max_wait [num_triggers-1];

  // single-cycle strobes back from the sequencer
  logic fire_pulse;
  logic early_pulse;
  logic late_pulse;

  modport regs (
    output arm, bypass, last_slot, min_wait, max_wait,
    input  fire_pulse, early_pulse, late_pulse
  );

  modport seq (
    input  arm, bypass, last_slot, min_wait, max_wait,
    output fire_pulse, early_pulse, late_pulse
  );

endinterface

/* trig_wb_regs.sv */
`timescale 1ns/1ps

module trig_wb_regs (
  input  logic                              adc_clk,
  input  logic                              arst_n,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [trig_pkg::wb_addr_width-1:0] wb_adr,
  input  logic [trig_pkg::wb_data_width-1:0] wb_dat_w,
  output logic [trig_pkg::wb_data_width-1:0] wb_dat_r,
  output logic                              wb_ack,
  seq_cfg_if.regs                           cfg
);
  import trig_pkg::*;

  logic                     access;
  logic                     wr_en;
  logic                     rearm;
  reg_addr_e                addr;
  logic                     arm_q;
  logic                     bypass_q;
  logic [slot_width-1:0]    last_slot_q;
  logic [counter_width-1:0] min_wait_q [num_triggers-1];
  logic [counter_width-1:0] max_wait_q [num_triggers-1];
  logic                     fired_q;
  logic                     early_q;
  logic                     late_q;
  logic [wb_data_width-1:0] rd_data;

  assign access = wb_cyc & wb_stb & ~wb_ack; // new transfer only
  assign wr_en  = access & wb_we;
  assign addr   = reg_addr_e'(wb_adr);
  assign rearm  = wr_en && (addr == reg_ctrl) && wb_dat_w[ctrl_arm_bit];

  // classic ack of one cycle per transfer
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      arm_q       <= 1'b0;
      bypass_q    <= 1'b0;
      last_slot_q <= '0;
    end else if (wr_en && addr == reg_ctrl) begin
      arm_q       <= wb_dat_w[ctrl_arm_bit];
      bypass_q    <= wb_dat_w[ctrl_bypass_bit];
      last_slot_q <= wb_dat_w[ctrl_slot_lsb +: slot_width];
    end else if (cfg.fire_pulse) begin
      arm_q <= 1'b0; // one shot
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_triggers - 1; i++) begin
        min_wait_q[i] <= '0;
        max_wait_q[i] <= '0;
      end
    end else if (wr_en) begin
      for (int i = 0; i < num_triggers - 1; i++) begin
        if (int'(addr) == int'(reg_min_wait0) + i) min_wait_q[i] <= wb_dat_w[counter_width-1:0];
        if (int'(addr) == int'(reg_max_wait0) + i) max_wait_q[i] <= wb_dat_w[counter_width-1:0];
      end
    end
  end

  // sticky status cleared when the host re-arms
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      fired_q <= 1'b0;
      early_q <= 1'b0;
      late_q  <= 1'b0;
    end else if (rearm) begin
      fired_q <= 1'b0;
      early_q <= 1'b0;
      late_q  <= 1'b0;
    end else begin
      if (cfg.fire_pulse)  fired_q <= 1'b1;
      if (cfg.early_pulse) early_q <= 1'b1;
      if (cfg.late_pulse)  late_q  <= 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    case (addr)
      reg_ctrl: begin
        rd_data[ctrl_arm_bit]                 = arm_q;
        rd_data[ctrl_bypass_bit]              = bypass_q;
        rd_data[ctrl_slot_lsb +: slot_width]  = last_slot_q;
      end
      reg_status: begin
        rd_data[stat_armed_bit] = arm_q;
        rd_data[stat_fired_bit] = fired_q;
        rd_data[stat_early_bit] = early_q;
        rd_data[stat_late_bit]  = late_q;
      end
      default: begin
        for (int i = 0; i < num_triggers - 1; i++) begin
          if (int'(addr) == int'(reg_min_wait0) + i) rd_data[counter_width-1:0] = min_wait_q[i];
          if (int'(addr) == int'(reg_max_wait0) + i) rd_data[counter_width-1:0] = max_wait_q[i];
        end
      end
    endcase
  end

  // read data lines up with ack
  always_ff @(posedge adc_clk) begin
    if (access) wb_dat_r <= rd_data;
  end

  assign cfg.arm       = arm_q;
  assign cfg.bypass    = bypass_q;
  assign cfg.last_slot = last_slot_q;
  assign cfg.min_wait  = min_wait_q;
  assign cfg.max_wait  = max_wait_q;

endmodule

/* trig_edge_detect.sv */
`timescale 1ns/1ps

module trig_edge_detect (
  input  logic                             adc_clk,
  input  logic                             arst_n,
  input  logic [trig_pkg::num_triggers-1:0] trig_in,
  output logic [trig_pkg::num_triggers-1:0] trig_edge,
  output logic                             trig0_raw
);
  import trig_pkg::*;

  logic [num_triggers-1:0] trig_r;  // first stage
  logic [num_triggers-1:0] trig_r2; // second stage

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      trig_r  <= '0;
      trig_r2 <= '0;
    end else begin
      trig_r  <= trig_in;
      trig_r2 <= trig_r;
    end
  end

  // rising edge per input
  assign trig_edge = trig_r & ~trig_r2;

  // unregistered path for bypass mode
  assign trig0_raw = trig_in[0];

endmodule

/* trigger_sequencer.sv */
`timescale 1ns/1ps

module trigger_sequencer (
  input  logic                             adc_clk,
  input  logic                             arst_n,
  input  logic [trig_pkg::num_triggers-1:0] trig_edge,
  input  logic                             trig0_raw,
  seq_cfg_if.seq                           cfg,
  output logic                             trig_out
);
  import trig_pkg::*;

  seq_state_e               state;
  seq_state_e               next_state;
  logic [slot_width-1:0]    slot;    // slot whose edge is expected
  logic [counter_width-1:0] gap_cnt;
  logic [counter_width-1:0] cur_min; // window for the current gap
  logic [counter_width-1:0] cur_max;
  logic                     slot_edge;
  logic                     take_edge;
  logic                     fire_d;
  logic                     fire_q;
  logic                     early_d;
  logic                     late_d;

  assign slot_edge = trig_edge[slot];

  always_comb begin
    next_state = state;
    take_edge  = 1'b0;
    fire_d     = 1'b0;
    early_d    = 1'b0;
    late_d     = 1'b0;
    case (state)
      st_idle: begin
        if (cfg.arm) next_state = st_wait_first;
      end
      st_wait_first: begin
        if (!cfg.arm) begin
          next_state = st_idle;
        end else if (trig_edge[0]) begin
          if (cfg.last_slot == '0) begin
            fire_d     = 1'b1; // single slot sequence
            next_state = st_idle;
          end else begin
            take_edge  = 1'b1;
            next_state = st_wait_next;
          end
        end
      end
      st_wait_next: begin
        if (!cfg.arm) begin
          next_state = st_idle;
        end else if (slot_edge && gap_cnt < cur_min) begin
          early_d = 1'b1; // keep waiting for this slot
        end else if (slot_edge && gap_cnt <= cur_max) begin
          if (slot == cfg.last_slot) begin
            fire_d     = 1'b1;
            next_state = st_idle;
          end else begin
            take_edge = 1'b1;
          end
        end else if (gap_cnt >= cur_max) begin
          // window closed without an edge
          late_d     = 1'b1;
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      slot    <= '0;
      gap_cnt <= '0;
      cur_min <= '0;
      cur_max <= '0;
      fire_q  <= 1'b0;
    end else begin
      state  <= next_state;
      fire_q <= fire_d;
      if (state == st_idle) begin
        slot    <= '0;
        cur_min <= cfg.min_wait[0];
        cur_max <= cfg.max_wait[0];
      end else if (take_edge) begin
        cur_min <= cfg.min_wait[slot]; // window for the gap after this slot
        cur_max <= cfg.max_wait[slot];
        slot    <= slot + 1'b1;
      end
      if (take_edge) begin
        gap_cnt <= counter_width'(1);
      end else if (state == st_wait_next) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

  assign cfg.fire_pulse  = fire_d;
  assign cfg.early_pulse = early_d;
  assign cfg.late_pulse  = late_d;

  assign trig_out = cfg.bypass ? trig0_raw : fire_q;

endmodule

/* trig_seq_top.sv */
`timescale 1ns/1ps

module trig_seq_top (
  input  logic                              adc_clk,
  input  logic                              arst_n,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [trig_pkg::wb_addr_width-1:0] wb_adr,
  input  logic [trig_pkg::wb_data_width-1:0] wb_dat_w,
  output logic [trig_pkg::wb_data_width-1:0] wb_dat_r,
  output logic                              wb_ack,
  input  logic [trig_pkg::num_triggers-1:0]  trig_in,
  output logic                              trig_out
);
  import trig_pkg::*;

  logic [num_triggers-1:0] trig_edge;
  logic                    trig0_raw; // bypass path

  seq_cfg_if u_cfg ();

  trig_wb_regs u_regs (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .cfg      (u_cfg.regs)
  );

  trig_edge_detect u_edge (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .trig_in   (trig_in),
    .trig_edge (trig_edge),
    .trig0_raw (trig0_raw)
  );

  trigger_sequencer u_seq (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .trig_edge (trig_edge),
    .trig0_raw (trig0_raw),
    .cfg       (u_cfg.seq),
    .trig_out  (trig_out)
  );

endmodule

/* trig_seq_assert.sv */
`timescale 1ns/1ps

module trig_seq_assert (
  input logic adc_clk,
  input logic arst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic bypass,
  input logic trig_out
);

  int fail_count = 0; // failed properties so far

  // ack only answers a live bus cycle
  ack_in_cycle: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $rose(wb_ack) |-> (wb_cyc && wb_stb))
    else begin
      $error("wb_ack rose without cyc and stb");
      fail_count++;
    end

  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held for two cycles");
      fail_count++;
    end

  // fire strobe is single cycle unless bypassed
  trig_one_cycle: assert property (@(posedge adc_clk) disable iff (!arst_n)
    (!bypass && trig_out) |=> (bypass || !trig_out))
    else begin
      $error("trig_out high for two cycles outside bypass");
      fail_count++;
    end

endmodule

bind trig_seq_top trig_seq_assert u_assert (
  .adc_clk  (adc_clk),
  .arst_n   (arst_n),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .bypass   (u_cfg.bypass),
  .trig_out (trig_out)
);

/* tb_trig_seq.sv */
`timescale 1ns/1ps

module tb_trig_seq;
  import trig_pkg::*;

  localparam int seq_len        = 260; // worst case for one armed sequence
  localparam int timeout_cycles = 4 * (150 + 22 * seq_len + 100 + 200);

  logic        adc_clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [3:0]  trig_in;
  logic        trig_out;

  logic [31:0] seed;
  int          cycle = 0;
  int          pulse_count;
  int          last_pulse_cycle;
  int          err_count;
  int          test_errs_start;
  int          tests_failed;
  bit          bypass_mode;
  int          m_last;
  int          m_min [3];
  int          m_max [3];
  int          ev_slot [$];  // trigger line of each pulse
  int          ev_gap [$];   // cycles since the previous pulse
  int          ev_cycle [$];

  trig_seq_top u_dut (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .trig_in  (trig_in),
    .trig_out (trig_out)
  );

  always #10 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("timeout: the run went past %0d cycles", timeout_cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // output pulses seen mid-cycle and ignored while bypassed
  always @(negedge adc_clk) begin
    if (trig_out && !bypass_mode) begin
      pulse_count = pulse_count + 1;
      last_pulse_cycle = cycle;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'((next_rand() >> 8) % (hi - lo + 1));
  endfunction

  // failed immediate checks plus failed bound properties
  function automatic int total_errors();
    return err_count + u_dut.u_assert.fail_count;
  endfunction

  task automatic next_cycle();
    @(posedge adc_clk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    next_cycle();
    while (!wb_ack && n < 16) begin
      next_cycle();
      n++;
    end
    assert (wb_ack) else begin
      $display("no ack came back from the bus within 16 cycles");
      err_count++;
    end
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack();
    next_cycle(); // stb held through the ack cycle
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    data = wb_dat_r;
    next_cycle();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic pulse_trigger(input int s);
    trig_in[s] = 1'b1;
    next_cycle();
    trig_in[s] = 1'b0;
  endtask

  // gap rule applied to the driven pulse list
  task automatic predict_outcome(output bit fire, output bit early, output bit late,
                                 output int fire_idx);
    int cur;
    int since;
    fire = 0;
    early = 0;
    late = 0;
    fire_idx = -1;
    cur = 0;
    since = 0;
    for (int i = 0; i < ev_slot.size() && !fire; i++) begin
      since = since + ev_gap[i];
      if (cur > 0 && since > m_max[cur-1]) begin
        late = 1; // window closed before this pulse
        cur = 0;
      end
      if (cur == 0) begin
        if (ev_slot[i] == 0 && m_last == 0) begin
          fire = 1;
          fire_idx = i;
        end else if (ev_slot[i] == 0) begin
          cur = 1;
          since = 0;
        end
      end else if (ev_slot[i] == cur) begin
        if (since < m_min[cur-1]) begin
          early = 1;
        end else if (cur == m_last) begin
          fire = 1;
          fire_idx = i;
        end else begin
          cur = cur + 1;
          since = 0;
        end
      end
    end
    if (!fire && cur > 0) late = 1; // the run waits past the last window
  endtask

  task automatic configure_and_arm();
    wb_write(reg_ctrl, 32'h0);
    for (int j = 0; j < 3; j++) begin
      wb_write(3'(int'(reg_min_wait0) + j), m_min[j]);
      wb_write(3'(int'(reg_max_wait0) + j), m_max[j]);
    end
    wb_write(reg_ctrl, 32'(m_last << 4) | 32'h1);
    wait_cycles(2); // idle then waiting for slot 0
  endtask

  task automatic run_sequence();
    bit          fire;
    bit          early;
    bit          late;
    int          fire_idx;
    logic [31:0] rd;
    logic [31:0] exp_status;
    configure_and_arm();
    pulse_count = 0;
    ev_cycle.delete();
    for (int i = 0; i < ev_slot.size(); i++) begin
      if (i > 0) wait_cycles(ev_gap[i] - 1);
      ev_cycle.push_back(cycle);
      pulse_trigger(ev_slot[i]);
    end
    wait_cycles(50);
    predict_outcome(fire, early, late, fire_idx);
    check_value("trig_out pulses", pulse_count, fire);
    if (fire) check_value("trig_out cycle", last_pulse_cycle, ev_cycle[fire_idx] + 2);
    exp_status = '0;
    exp_status[0] = !fire; // arm drops only on a fire
    exp_status[1] = fire;
    exp_status[2] = early;
    exp_status[3] = late;
    wb_read(reg_status, rd);
    check_value("wb_dat_r status", rd, exp_status);
    wb_read(reg_ctrl, rd);
    check_value("wb_dat_r ctrl", rd, 32'(m_last << 4) | 32'(!fire));
  endtask

  task automatic report_test(input string name);
    if (total_errors() == test_errs_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, total_errors() - test_errs_start);
      tests_failed++;
    end
    test_errs_start = total_errors();
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] wdata;
    int          lo;
    adc_clk = 1'b0;
    arst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    trig_in = '0;
    seed = 32'habaa98ef;
    bypass_mode = 1'b0;
    pulse_count = 0;
    last_pulse_cycle = 0;
    err_count = 0;
    test_errs_start = 0;
    tests_failed = 0;
    repeat (10) @(posedge adc_clk);
    #2 arst_n = 1'b1;
    next_cycle();

    for (int r = 0; r < 3; r++) begin
      for (int a = 2; a < 8; a++) begin
        wdata = next_rand();
        wb_write(3'(a), wdata);
        wb_read(3'(a), rd);
        check_value("wb_dat_r window", rd, wdata & 32'hffff);
      end
      wdata = next_rand();
      wb_write(reg_ctrl, wdata);
      wb_read(reg_ctrl, rd);
      check_value("wb_dat_r ctrl", rd, wdata & 32'h33);
      wb_write(reg_status, next_rand()); // read only so the write must not stick
      wb_read(reg_status, rd);
      check_value("wb_dat_r status", rd, wdata & 32'h1); // armed bit, no sticky bits yet
    end
    wb_write(reg_ctrl, 32'h0);
    report_test("register readback");

    for (int n = 0; n < 20; n++) begin
      m_last = rand_range(0, 3);
      for (int j = 0; j < 3; j++) begin
        m_min[j] = rand_range(2, 37);
        m_max[j] = rand_range(m_min[j] + 3, 40);
      end
      ev_slot.delete();
      ev_gap.delete();
      ev_slot.push_back(0);
      ev_gap.push_back(0);
      for (int s = 1; s <= m_last; s++) begin
        lo = (m_min[s-1] < 3) ? 3 : m_min[s-1]; // pulses need two low cycles
        ev_slot.push_back(s);
        ev_gap.push_back(rand_range(lo, m_max[s-1]));
      end
      run_sequence();
    end
    report_test("in-window sequences");

    m_last = 1;
    m_min = '{4, 4, 4};
    m_max = '{10, 10, 10};
    ev_slot = {0, 1, 0, 1};
    ev_gap = {0, 14, 20, 7};
    run_sequence();
    report_test("too late then valid");

    m_last = 1;
    m_min = '{10, 10, 10};
    m_max = '{30, 30, 30};
    ev_slot = {0, 1, 1};
    ev_gap = {0, 4, 11};
    run_sequence();
    report_test("too early then valid");

    bypass_mode = 1'b1;
    wb_write(reg_ctrl, 32'h2);
    for (int k = 0; k < 30; k++) begin
      trig_in = 4'(next_rand() >> 12);
      #1;
      check_value("trig_out", trig_out, trig_in[0]);
      next_cycle();
    end
    trig_in = '0;
    wb_write(reg_ctrl, 32'h0);
    next_cycle();
    bypass_mode = 1'b0;
    report_test("bypass");

    m_last = 3;
    m_min = '{3, 3, 3};
    m_max = '{20, 20, 20};
    configure_and_arm();
    pulse_count = 0;
    pulse_trigger(0);
    wait_cycles(4);
    pulse_trigger(1);
    wait_cycles(2);
    wb_write(reg_ctrl, 32'h30); // arm off mid-sequence
    pulse_trigger(2);
    wait_cycles(4);
    pulse_trigger(3);
    wait_cycles(30);
    check_value("trig_out pulses", pulse_count, 0);
    wb_read(reg_status, rd);
    check_value("wb_dat_r status", rd, 32'h0);
    report_test("disarm");

    $display("tests run: 6, tests failed: %0d, checks failed: %0d", tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* flist.f */
trig_pkg.sv
seq_cfg_if.sv
trig_wb_regs.sv
trig_edge_detect.sv
trigger_sequencer.sv
trig_seq_top.sv
trig_seq_assert.sv
tb_trig_seq.sv

/* Bender.yml */
package:
  name: trig_seq

sources:
  - trig_pkg.sv
  - seq_cfg_if.sv
  - trig_wb_regs.sv
  - trig_edge_detect.sv
  - trigger_sequencer.sv
  - trig_seq_top.sv
  - target: test
    files:
      - trig_seq_assert.sv
      - tb_trig_seq.sv
